//--- source/dcache_pkg.sv
`default_nettype none

package dcache_pkg;

	// geometry
	localparam int ADDR_W         = 32;
	localparam int WORD_W         = 64;
	localparam int BYTES_PER_WORD = 8;
	localparam int WORDS_PER_LINE = 8;
	localparam int LINE_W         = 512;
	localparam int NUM_SETS       = 16;
	localparam int NUM_WAYS       = 2;

	localparam int OFFSET_W   = $clog2(LINE_W / 8);
	localparam int WORD_SEL_W = $clog2(WORDS_PER_LINE);
	localparam int INDEX_W    = $clog2(NUM_SETS);
	localparam int TAG_W      = ADDR_W - INDEX_W - OFFSET_W;

	typedef logic [WORD_W-1:0]            word_t;
	typedef logic [LINE_W-1:0]            line_t; // word 0 in low bits
	typedef logic [BYTES_PER_WORD-1:0]    byte_en_t;
	typedef logic [TAG_W-1:0]             tag_t;
	typedef logic [INDEX_W-1:0]           index_t;
	typedef logic [$clog2(NUM_WAYS)-1:0]  way_t;

	typedef struct packed {
		tag_t                             tag;
		index_t                           index;
		logic [WORD_SEL_W-1:0]            word_sel;
		logic [OFFSET_W-WORD_SEL_W-1:0]   byte_off;
	} cache_addr_t;

	typedef struct packed {
		logic        valid;
		logic        write;
		cache_addr_t addr;
		word_t       wdata;
		byte_en_t    byte_en;
	} cpu_req_t;

	typedef struct packed {
		logic  valid;
		word_t rdata;
	} cpu_resp_t;

	typedef struct packed {
		logic              cyc;
		logic              write;
		logic [ADDR_W-1:0] addr;
		word_t             data;
	} mem_req_t;

	typedef struct packed {
		logic  ack;
		logic  beat; // one returning read word
		word_t data;
	} mem_resp_t;

	typedef struct packed {
		logic   touch;
		logic   fill;
		logic   set_dirty;
		logic   clear_dirty;
		way_t   way;
		index_t index;
		tag_t   tag;
	} tag_update_t;

	typedef struct packed {
		logic                  word_we;
		logic                  line_we;
		way_t                  way; // also the read way
		index_t                index;
		logic [WORD_SEL_W-1:0] word_sel;
		byte_en_t              byte_en;
		word_t                 wdata;
		line_t                 line;
	} data_write_t;

	typedef struct packed {
		logic                       start;
		logic                       write;
		logic [ADDR_W-OFFSET_W-1:0] line_addr;
		line_t                      line;
	} line_cmd_t;

endpackage

`default_nettype wire

//--- source/dcache_tag_store.sv
`default_nettype none
`timescale 1ns/10ps

module dcache_tag_store (
	input  wire                       clk,
	input  wire                       reset,
	input  dcache_pkg::cache_addr_t   lookup_addr,
	input  dcache_pkg::tag_update_t   update,
	output logic                      hit,
	output dcache_pkg::way_t          hit_way,
	output dcache_pkg::way_t          victim_way,
	output logic                      victim_dirty,
	output dcache_pkg::tag_t          victim_tag
);
	import dcache_pkg::*;

	tag_t                              tag_mem [NUM_WAYS][NUM_SETS];
	logic [NUM_WAYS-1:0][NUM_SETS-1:0] valid_q;
	logic [NUM_WAYS-1:0][NUM_SETS-1:0] dirty_q;
	logic [NUM_SETS-1:0]               lru_q; // lru way of each set
	logic [NUM_WAYS-1:0]               way_hit;
	index_t                            idx;

	assign idx = lookup_addr.index;

	always_comb begin
		for (int w = 0; w < NUM_WAYS; w++) begin
			way_hit[w] = valid_q[w][idx] && (tag_mem[w][idx] == lookup_addr.tag);
		end
	end

	assign hit     = |way_hit;
	assign hit_way = way_t'(way_hit[1]);

	// replace the least recently used way
	assign victim_way   = lru_q[idx];
	assign victim_dirty = valid_q[victim_way][idx] && dirty_q[victim_way][idx];
	assign victim_tag   = tag_mem[victim_way][idx];

	always_ff @(posedge clk) begin
		if (reset) begin
			valid_q <= '0;
			lru_q   <= '0;
		end else begin
			if (update.fill) begin
				valid_q[update.way][update.index] <= 1'b1;
			end
			if (update.fill || update.touch) begin
				lru_q[update.index] <= ~update.way; // other way becomes lru
			end
		end
	end

	always_ff @(posedge clk) begin
		if (update.fill) begin
			tag_mem[update.way][update.index] <= update.tag;
		end
		if (update.fill || update.clear_dirty) begin
			dirty_q[update.way][update.index] <= 1'b0;
		end else if (update.set_dirty) begin
			dirty_q[update.way][update.index] <= 1'b1;
		end
	end

endmodule

`default_nettype wire

//--- source/dcache_data_store.sv
`default_nettype none
`timescale 1ns/10ps

module dcache_data_store (
	input  wire                       clk,
	input  dcache_pkg::way_t          read_way,
	input  dcache_pkg::cache_addr_t   read_addr,
	input  dcache_pkg::data_write_t   write,
	output dcache_pkg::word_t         rdata,
	output dcache_pkg::line_t         victim_line
);
	import dcache_pkg::*;

	word_t data_mem [NUM_WAYS][NUM_SETS][WORDS_PER_LINE];

	always_ff @(posedge clk) begin
		if (write.line_we) begin
			// refill replaces the whole line
			for (int i = 0; i < WORDS_PER_LINE; i++) begin
				data_mem[write.way][write.index][i] <= write.line[i*WORD_W +: WORD_W];
			end
		end else if (write.word_we) begin
			for (int b = 0; b < BYTES_PER_WORD; b++) begin
				if (write.byte_en[b]) begin
					data_mem[write.way][write.index][write.word_sel][b*8 +: 8] <=
						write.wdata[b*8 +: 8];
				end
			end
		end
	end

	assign rdata = data_mem[read_way][read_addr.index][read_addr.word_sel];

	always_comb begin
		for (int i = 0; i < WORDS_PER_LINE; i++) begin
			victim_line[i*WORD_W +: WORD_W] = data_mem[read_way][read_addr.index][i];
		end
	end

endmodule

`default_nettype wire

//--- source/dcache_ctrl.sv
`default_nettype none
`timescale 1ns/10ps

module dcache_ctrl (
	input  wire                       clk,
	input  wire                       reset,
	input  dcache_pkg::cpu_req_t      cpu_req,
	output dcache_pkg::cpu_resp_t     cpu_resp,
	input  wire                       hit,
	input  dcache_pkg::way_t          hit_way,
	input  dcache_pkg::way_t          victim_way,
	input  wire                       victim_dirty,
	input  dcache_pkg::tag_t          victim_tag,
	input  dcache_pkg::word_t         rdata,
	input  dcache_pkg::line_t         victim_line,
	output dcache_pkg::tag_update_t   tag_update,
	output dcache_pkg::data_write_t   data_write,
	output dcache_pkg::line_cmd_t     line_cmd,
	input  wire                       done,
	input  dcache_pkg::line_t         fill_line
);
	import dcache_pkg::*;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_RESPOND,
		ST_WRITEBACK,
		ST_REFILL
	} state_t;

	state_t state_q, state_d;
	word_t  rdata_q;
	way_t   way_q;
	way_t   sel_way;
	logic   idle_req;
	logic   hit_req;

	assign idle_req = (state_q == ST_IDLE) && cpu_req.valid;
	assign hit_req  = idle_req && hit;

	// hit way on a hit, lru way on a miss, held way while the miss runs
	assign sel_way = (state_q == ST_IDLE) ? (hit ? hit_way : victim_way) : way_q;

	always_comb begin
		state_d            = state_q;
		line_cmd.start     = 1'b0;
		line_cmd.write     = 1'b0;
		line_cmd.line_addr = {cpu_req.addr.tag, cpu_req.addr.index};
		line_cmd.line      = victim_line;
		case (state_q)
			ST_IDLE: begin
				if (cpu_req.valid) begin
					if (hit) begin
						state_d = ST_RESPOND;
					end else if (victim_dirty) begin
						line_cmd.start     = 1'b1;
						line_cmd.write     = 1'b1;
						line_cmd.line_addr = {victim_tag, cpu_req.addr.index};
						state_d            = ST_WRITEBACK;
					end else begin
						line_cmd.start = 1'b1;
						state_d        = ST_REFILL;
					end
				end
			end
			ST_RESPOND: state_d = ST_IDLE; // request ignored here
			ST_WRITEBACK: begin
				if (done) begin
					line_cmd.start = 1'b1; // go straight to the refill read
					state_d        = ST_REFILL;
				end
			end
			ST_REFILL: begin
				if (done) begin
					state_d = ST_IDLE; // replay as a hit
				end
			end
			default: state_d = ST_IDLE;
		endcase
	end

	always_comb begin
		tag_update.touch       = hit_req;
		tag_update.fill        = (state_q == ST_REFILL) && done;
		tag_update.set_dirty   = hit_req && cpu_req.write;
		tag_update.clear_dirty = (state_q == ST_WRITEBACK) && done;
		tag_update.way         = sel_way;
		tag_update.index       = cpu_req.addr.index;
		tag_update.tag         = cpu_req.addr.tag;
	end

	always_comb begin
		data_write.word_we  = hit_req && cpu_req.write;
		data_write.line_we  = (state_q == ST_REFILL) && done;
		data_write.way      = sel_way;
		data_write.index    = cpu_req.addr.index;
		data_write.word_sel = cpu_req.addr.word_sel;
		data_write.byte_en  = cpu_req.byte_en;
		data_write.wdata    = cpu_req.wdata;
		data_write.line     = fill_line;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state_q <= ST_IDLE;
		end else begin
			state_q <= state_d;
		end
	end

	always_ff @(posedge clk) begin
		if (idle_req) begin
			rdata_q <= rdata;
			way_q   <= sel_way;
		end
	end

	assign cpu_resp.valid = (state_q == ST_RESPOND);
	assign cpu_resp.rdata = rdata_q;

endmodule

`default_nettype wire

//--- source/dcache_line_bus.sv
`default_nettype none
`timescale 1ns/10ps

module dcache_line_bus (
	input  wire                     clk,
	input  wire                     reset,
	input  dcache_pkg::line_cmd_t   cmd,
	output dcache_pkg::mem_req_t    mem_req,
	input  dcache_pkg::mem_resp_t   mem_resp,
	output logic                    done,
	output dcache_pkg::line_t       fill_line
);
	import dcache_pkg::*;

	typedef enum logic [1:0] {
		BUS_IDLE,
		BUS_SEND, // write beats or the read request
		BUS_RECV
	} bus_state_t;

	bus_state_t                 state_q;
	logic [WORD_SEL_W-1:0]      beat_q;
	logic                       write_q;
	logic                       done_q;
	logic [ADDR_W-OFFSET_W-1:0] line_addr_q;
	line_t                      line_q;
	line_t                      fill_q;
	logic                       last_beat;

	assign last_beat = (beat_q == WORD_SEL_W'(WORDS_PER_LINE - 1));

	always_ff @(posedge clk) begin
		if (reset) begin
			state_q <= BUS_IDLE;
			beat_q  <= '0;
			write_q <= 1'b0;
			done_q  <= 1'b0;
		end else begin
			done_q <= 1'b0;
			case (state_q)
				BUS_IDLE: begin
					if (cmd.start) begin
						write_q <= cmd.write;
						beat_q  <= '0;
						state_q <= BUS_SEND;
					end
				end
				BUS_SEND: begin
					if (mem_resp.ack) begin
						if (!write_q) begin
							state_q <= BUS_RECV;
						end else if (last_beat) begin
							done_q  <= 1'b1;
							state_q <= BUS_IDLE;
						end else begin
							beat_q <= beat_q + 1'b1;
						end
					end
				end
				BUS_RECV: begin
					if (mem_resp.beat) begin
						if (last_beat) begin
							done_q  <= 1'b1;
							state_q <= BUS_IDLE;
						end else begin
							beat_q <= beat_q + 1'b1;
						end
					end
				end
				default: state_q <= BUS_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state_q == BUS_IDLE && cmd.start) begin
			line_addr_q <= cmd.line_addr;
			line_q      <= cmd.line;
		end
		if (state_q == BUS_RECV && mem_resp.beat) begin
			fill_q[beat_q*WORD_W +: WORD_W] <= mem_resp.data;
		end
	end

	always_comb begin
		mem_req.cyc   = (state_q == BUS_SEND);
		mem_req.write = (state_q == BUS_SEND) && write_q;
		if (write_q) begin
			mem_req.addr = {line_addr_q, beat_q, {(OFFSET_W - WORD_SEL_W){1'b0}}};
		end else begin
			mem_req.addr = {line_addr_q, {OFFSET_W{1'b0}}}; // line aligned
		end
		mem_req.data = line_q[beat_q*WORD_W +: WORD_W];
	end

	assign done      = done_q;
	assign fill_line = fill_q;

endmodule

`default_nettype wire

//--- source/dcache_top.sv
`default_nettype none
`timescale 1ns/10ps

module dcache_top (
	input  wire                     clk,
	input  wire                     reset,
	input  dcache_pkg::cpu_req_t    cpu_req,
	output dcache_pkg::cpu_resp_t   cpu_resp,
	output dcache_pkg::mem_req_t    mem_req,
	input  dcache_pkg::mem_resp_t   mem_resp
);
	import dcache_pkg::*;

	logic        hit;
	way_t        hit_way;
	way_t        victim_way;
	logic        victim_dirty;
	tag_t        victim_tag;
	word_t       rdata;
	line_t       victim_line;
	line_t       fill_line;
	tag_update_t tag_update;
	data_write_t data_write;
	line_cmd_t   line_cmd;
	logic        done;

	dcache_ctrl u_ctrl (
		.clk          (clk),
		.reset        (reset),
		.cpu_req      (cpu_req),
		.cpu_resp     (cpu_resp),
		.hit          (hit),
		.hit_way      (hit_way),
		.victim_way   (victim_way),
		.victim_dirty (victim_dirty),
		.victim_tag   (victim_tag),
		.rdata        (rdata),
		.victim_line  (victim_line),
		.tag_update   (tag_update),
		.data_write   (data_write),
		.line_cmd     (line_cmd),
		.done         (done),
		.fill_line    (fill_line)
	);

	dcache_tag_store u_tag_store (
		.clk          (clk),
		.reset        (reset),
		.lookup_addr  (cpu_req.addr),
		.update       (tag_update),
		.hit          (hit),
		.hit_way      (hit_way),
		.victim_way   (victim_way),
		.victim_dirty (victim_dirty),
		.victim_tag   (victim_tag)
	);

	// controller's chosen way doubles as the read way
	dcache_data_store u_data_store (
		.clk         (clk),
		.read_way    (data_write.way),
		.read_addr   (cpu_req.addr),
		.write       (data_write),
		.rdata       (rdata),
		.victim_line (victim_line)
	);

	dcache_line_bus u_line_bus (
		.clk       (clk),
		.reset     (reset),
		.cmd       (line_cmd),
		.mem_req   (mem_req),
		.mem_resp  (mem_resp),
		.done      (done),
		.fill_line (fill_line)
	);

endmodule

`default_nettype wire

//--- testbench/tb_mem_model.sv
`default_nettype none
`timescale 1ns/10ps

module tb_mem_model (
	input  wire                     clk,
	input  wire                     reset,
	input  dcache_pkg::mem_req_t    mem_req,
	output dcache_pkg::mem_resp_t   mem_resp
);
	import dcache_pkg::*;

	word_t       mem [logic [28:0]]; // indexed by word address
	logic [31:0] read_log[$];
	logic [31:0] write_addr_log[$];
	word_t       write_data_log[$];

	// every address bit shows up in the pattern
	function automatic word_t init_word(input logic [28:0] wa);
		return {3'b101, wa, 3'b010, ~wa};
	endfunction

	function automatic word_t read_word(input logic [28:0] wa);
		if (mem.exists(wa)) begin
			return mem[wa];
		end
		return init_word(wa);
	endfunction

	function automatic int num_reads();
		return read_log.size();
	endfunction

	function automatic int num_writes();
		return write_addr_log.size();
	endfunction

	function automatic logic [31:0] read_addr(input int i);
		return read_log[i];
	endfunction

	function automatic logic [31:0] write_addr(input int i);
		return write_addr_log[i];
	endfunction

	function automatic word_t write_data(input int i);
		return write_data_log[i];
	endfunction

	task automatic clear_log();
		read_log.delete();
		write_addr_log.delete();
		write_data_log.delete();
	endtask

	initial begin
		mem_req_t    req;
		logic [28:0] base;
		mem_resp = '0;
		forever begin
			@(negedge clk);
			if (!reset && mem_req.cyc) begin
				repeat ($urandom_range(3)) @(negedge clk); // ack delay
				req          = mem_req;
				mem_resp.ack = 1'b1;
				if (req.write) begin
					mem[req.addr[31:3]] = req.data;
					write_addr_log.push_back(req.addr);
					write_data_log.push_back(req.data);
				end else begin
					read_log.push_back(req.addr);
				end
				@(negedge clk);
				mem_resp.ack = 1'b0;
				if (!req.write) begin
					base = req.addr[31:3];
					for (int i = 0; i < WORDS_PER_LINE; i++) begin
						repeat ($urandom_range(2)) @(negedge clk); // gap before beat
						mem_resp.beat = 1'b1;
						mem_resp.data = read_word(base + 29'(i));
						@(negedge clk);
						mem_resp.beat = 1'b0;
					end
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- testbench/tb_dcache.sv
`default_nettype none
`timescale 1ns/10ps

module tb_dcache;
	import dcache_pkg::*;

	localparam int RESP_TIMEOUT = 2000;

	logic      clk;
	logic      reset;
	cpu_req_t  cpu_req;
	cpu_resp_t cpu_resp;
	mem_req_t  mem_req;
	mem_resp_t mem_resp;

	int        errors = 0;
	int        checks = 0;
	int        req_count = 0;
	int        resp_count = 0;
	string     exp_name = "";
	logic      exp_read = 1'b0;
	word_t     exp_data = '0;
	word_t     ref_mem [logic [28:0]]; // program order view of memory

	dcache_top u_dut (
		.clk      (clk),
		.reset    (reset),
		.cpu_req  (cpu_req),
		.cpu_resp (cpu_resp),
		.mem_req  (mem_req),
		.mem_resp (mem_resp)
	);

	tb_mem_model u_mem (
		.clk      (clk),
		.reset    (reset),
		.mem_req  (mem_req),
		.mem_resp (mem_resp)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	function automatic word_t expected_read(input logic [31:0] addr);
		if (ref_mem.exists(addr[31:3])) begin
			return ref_mem[addr[31:3]];
		end
		return u_mem.init_word(addr[31:3]);
	endfunction

	function automatic void ref_write(input logic [31:0] addr, input word_t data,
			input byte_en_t be);
		word_t w;
		w = expected_read(addr);
		for (int b = 0; b < BYTES_PER_WORD; b++) begin
			if (be[b]) begin
				w[b*8 +: 8] = data[b*8 +: 8];
			end
		end
		ref_mem[addr[31:3]] = w;
	endfunction

	function automatic logic [31:0] line_addr(input int tag, input int set);
		return {22'(tag), 4'(set), 6'b0};
	endfunction

	task automatic check_value(input string name, input logic [63:0] exp, input logic [63:0] act);
		checks++;
		if (exp !== act) begin
			errors++;
			$display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	task automatic finish_run();
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	endtask

	task automatic abort_run(input string msg);
		errors++;
		$display("ERROR: %s", msg);
		finish_run();
	endtask

	// one count per response pulse
	always @(negedge clk) begin
		if (!reset && cpu_resp.valid) begin
			if (resp_count >= req_count) begin
				errors++;
				$display("ERROR: cache response with no request outstanding");
			end
			resp_count++;
			if (exp_read) begin
				check_value(exp_name, exp_data, cpu_resp.rdata);
			end
		end
	end

	task automatic wait_response();
		int cycles;
		cycles = 0;
		while (resp_count < req_count) begin
			@(posedge clk);
			cycles++;
			if (cycles > RESP_TIMEOUT) begin
				abort_run($sformatf("no cache response for %s", exp_name));
			end
		end
	endtask

	task automatic access(input string name, input logic write, input logic [31:0] addr,
			input word_t wdata, input byte_en_t be);
		@(negedge clk);
		cpu_req.valid   = 1'b1;
		cpu_req.write   = write;
		cpu_req.addr    = addr;
		cpu_req.wdata   = wdata;
		cpu_req.byte_en = be;
		exp_name        = name;
		exp_read        = !write;
		if (write) begin
			ref_write(addr, wdata, be);
		end else begin
			exp_data = expected_read(addr);
		end
		req_count++;
		wait_response();
		@(negedge clk);
		cpu_req.valid = 1'b0;
	endtask

	// each written back word must match the reference when it leaves the cache
	task automatic check_writebacks(input string name, input int first);
		for (int i = first; i < u_mem.num_writes(); i++) begin
			check_value(name, expected_read(u_mem.write_addr(i)), u_mem.write_data(i));
		end
	endtask

	initial begin
		logic [31:0] addr;
		int          mark;
		void'($urandom(32'h49ae));
		cpu_req = '0;
		reset   = 1'b1;
		repeat (3) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		repeat (5) @(posedge clk);
		check_value("no response after reset", 64'(0), 64'(resp_count));

		// cold read
		access("cold read", 1'b0, 32'h0000_1238, '0, '0);
		check_value("cold read requests", 64'(1), 64'(u_mem.num_reads()));
		check_value("cold read line base", 64'h1200, 64'(u_mem.read_addr(0)));
		check_value("cold read writes", 64'(0), 64'(u_mem.num_writes()));

		access("masked write", 1'b1, 32'h0000_1238, 64'h0123_4567_89ab_cdef, 8'b1010_0101);
		u_mem.clear_log();
		access("masked read back", 1'b0, 32'h0000_1238, '0, '0);
		check_value("hit read bus traffic", 64'(0), 64'(u_mem.num_reads() + u_mem.num_writes()));

		// lru in set 5
		access("lru read a", 1'b0, line_addr('h10, 5), '0, '0);
		access("lru read b", 1'b0, line_addr('h11, 5), '0, '0);
		access("lru read a again", 1'b0, line_addr('h10, 5) + 32'h8, '0, '0);
		u_mem.clear_log();
		access("lru read c", 1'b0, line_addr('h12, 5), '0, '0);
		check_value("clean eviction writes", 64'(0), 64'(u_mem.num_writes()));
		u_mem.clear_log();
		access("lru a kept", 1'b0, line_addr('h10, 5) + 32'h10, '0, '0);
		check_value("lru a kept reads", 64'(0), 64'(u_mem.num_reads()));
		access("lru b evicted", 1'b0, line_addr('h11, 5), '0, '0);
		check_value("lru b evicted reads", 64'(1), 64'(u_mem.num_reads()));

		// dirty eviction in set 9
		access("wb write d3", 1'b1, line_addr('h20, 9) + 32'd24, 64'hfeed_face_cafe_beef, 8'hff);
		access("wb write d6", 1'b1, line_addr('h20, 9) + 32'd48, 64'h1111_2222_3333_4444, 8'h3c);
		access("wb read e", 1'b0, line_addr('h21, 9), '0, '0);
		u_mem.clear_log();
		access("wb read f", 1'b0, line_addr('h22, 9), '0, '0);
		check_value("wb beats", 64'(8), 64'(u_mem.num_writes()));
		for (int i = 0; i < u_mem.num_writes(); i++) begin
			check_value("wb address", 64'(line_addr('h20, 9) + 32'(i * 8)),
				64'(u_mem.write_addr(i)));
		end
		check_writebacks("wb data", 0);
		check_value("wb refill base", 64'(line_addr('h22, 9)), 64'(u_mem.read_addr(0)));
		u_mem.clear_log();
		access("wb read g", 1'b0, line_addr('h23, 9), '0, '0);
		check_value("unwritten eviction writes", 64'(0), 64'(u_mem.num_writes()));

		// random mix over sets 0..3 and six tags
		for (int n = 0; n < 300; n++) begin
			addr = line_addr('h100 + $urandom_range(5), $urandom_range(3));
			addr = addr + 32'($urandom_range(7) * 8);
			mark = u_mem.num_writes();
			if ($urandom_range(1) == 1) begin
				access("random write", 1'b1, addr, {$urandom, $urandom}, 8'($urandom));
			end else begin
				access("random read", 1'b0, addr, '0, '0);
			end
			check_writebacks("random writeback", mark);
		end
		// push every random line out to memory
		for (int s = 0; s < 4; s++) begin
			for (int t = 0; t < 2; t++) begin
				mark = u_mem.num_writes();
				access("flush read", 1'b0, line_addr('h200 + t, s), '0, '0);
				check_writebacks("flush writeback", mark);
			end
		end
		for (int t = 0; t < 6; t++) begin
			for (int s = 0; s < 4; s++) begin
				for (int w = 0; w < WORDS_PER_LINE; w++) begin
					addr = line_addr('h100 + t, s) + 32'(w * 8);
					check_value("memory after flush", expected_read(addr),
						u_mem.read_word(addr[31:3]));
				end
			end
		end

		repeat (20) @(posedge clk);
		check_value("one response per request", 64'(req_count), 64'(resp_count));
		finish_run();
	end

endmodule

`default_nettype wire

//--- vlog.f
source/dcache_pkg.sv
source/dcache_tag_store.sv
source/dcache_data_store.sv
source/dcache_ctrl.sv
source/dcache_line_bus.sv
source/dcache_top.sv
testbench/tb_mem_model.sv
testbench/tb_dcache.sv

//--- Bender.yml
package:
  name: dcache

sources:
  - files:
      - source/dcache_pkg.sv
      - source/dcache_tag_store.sv
      - source/dcache_data_store.sv
      - source/dcache_ctrl.sv
      - source/dcache_line_bus.sv
      - source/dcache_top.sv
  - target: simulation
    files:
      - testbench/tb_mem_model.sv
      - testbench/tb_dcache.sv
